// ==== verilog/vliw_pkg.sv ====
// ============================================================
// Shared types and constants for the fractal VLIW datapath.
// Modules import this package for the word and address
// types, the register map and the fixed-point limits.
// ============================================================
`default_nettype none

package vliw_pkg;

   localparam int NUM_REGS    = 8;
   localparam int FRAC_BITS   = 22;
   localparam int ADD_LATENCY = 3;

   // Signed fixed point, 22 fraction bits
   typedef logic signed [26:0] word_t;
   typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

   // Architectural register map
   localparam reg_addr_t ADDR_Z_RE = 3'd0;
   localparam reg_addr_t ADDR_Z_IM = 3'd1;
   localparam reg_addr_t ADDR_MAG  = 3'd2;

   localparam word_t WORD_MAX = {1'b0, {26{1'b1}}};
   localparam word_t WORD_MIN = {1'b1, {26{1'b0}}};

   // One half in 5.22 format
   localparam word_t ESCAPE_LIMIT = word_t'(1 << 21);

endpackage

`default_nettype wire

// ==== verilog/wb_if.sv ====
// ============================================================
// Write-back bundle from the execution lanes to the register
// file. One valid/dest/data group per lane, landing at the
// next rising clock edge.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
   import vliw_pkg::*;

   logic      ld_valid, neg_valid, add_valid, mul_valid;
   reg_addr_t ld_dest, neg_dest, add_dest, mul_dest;
   word_t     ld_data, neg_data, add_data, mul_data;

   modport lanes (
      output ld_valid, ld_dest, ld_data,
      output neg_valid, neg_dest, neg_data,
      output add_valid, add_dest, add_data,
      output mul_valid, mul_dest, mul_data
   );

   modport rf (
      input ld_valid, ld_dest, ld_data,
      input neg_valid, neg_dest, neg_data,
      input add_valid, add_dest, add_data,
      input mul_valid, mul_dest, mul_data
   );

endinterface

`default_nettype wire

// ==== verilog/fx_add_pipe.sv ====
// ============================================================
// Three-stage saturating fixed-point adder. The sum is formed
// and clipped in the first stage, then it travels with its
// valid bit and destination through the remaining stages.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module fx_add_pipe (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           in_valid,
   input  wire vliw_pkg::reg_addr_t in_dest,
   input  wire vliw_pkg::word_t a,
   input  wire vliw_pkg::word_t b,
   output logic               out_valid,
   output vliw_pkg::reg_addr_t out_dest,
   output vliw_pkg::word_t    sum
);
   import vliw_pkg::*;

   logic signed [27:0]     wide_sum;
   word_t                  sat_sum;
   logic [ADD_LATENCY-1:0] vld_q;
   word_t                  sum_q  [ADD_LATENCY];
   reg_addr_t              dest_q [ADD_LATENCY];

   // One guard bit catches overflow
   assign wide_sum = a + b;

   always_comb begin
      if (wide_sum > WORD_MAX) begin
         sat_sum = WORD_MAX;
      end else if (wide_sum < WORD_MIN) begin
         sat_sum = WORD_MIN;
      end else begin
         sat_sum = wide_sum[26:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[ADD_LATENCY-2:0], in_valid};
      end
   end

   always_ff @(posedge clk) begin
      sum_q[0]  <= sat_sum;
      dest_q[0] <= in_dest;
      for (int i = 1; i < ADD_LATENCY; i++) begin
         sum_q[i]  <= sum_q[i-1];
         dest_q[i] <= dest_q[i-1];
      end
   end

   assign out_valid = vld_q[ADD_LATENCY-1];
   assign out_dest  = dest_q[ADD_LATENCY-1];
   assign sum       = sum_q[ADD_LATENCY-1];

   a_add_latency: assert property (@(posedge clk) disable iff (rst)
      in_valid |-> ##ADD_LATENCY out_valid)
      else $error("Add result missing after issue");

endmodule

`default_nettype wire

// ==== verilog/fx_mul.sv ====
// ============================================================
// Combinational fixed-point multiplier. Full signed product,
// realigned by an arithmetic shift of the fraction width and
// clipped to the word range.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module fx_mul (
   input  wire vliw_pkg::word_t a,
   input  wire vliw_pkg::word_t b,
   output vliw_pkg::word_t product
);
   import vliw_pkg::*;

   logic signed [53:0] full_prod;
   logic signed [53:0] shifted;

   assign full_prod = a * b;

   // Arithmetic shift rounds toward minus infinity
   assign shifted = full_prod >>> FRAC_BITS;

   always_comb begin
      if (shifted > WORD_MAX) begin
         product = WORD_MAX;
      end else if (shifted < WORD_MIN) begin
         product = WORD_MIN;
      end else begin
         product = shifted[26:0];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/exec_lanes.sv ====
// ============================================================
// Execution stage of the VLIW bundle. Forms the load, negate,
// add and multiply results and drives them onto write-back.
// Load, negate and multiply complete in the issue cycle; the
// add lane comes out of the three-stage adder.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module exec_lanes (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           ld_en,
   input  wire vliw_pkg::reg_addr_t ld_dest,
   input  wire vliw_pkg::word_t ld_value,
   input  wire logic           neg_en,
   input  wire vliw_pkg::reg_addr_t neg_dest,
   input  wire logic           add_en,
   input  wire vliw_pkg::reg_addr_t add_dest,
   input  wire logic           mul_en,
   input  wire vliw_pkg::reg_addr_t mul_dest,
   input  wire vliw_pkg::word_t neg_opnd,
   input  wire vliw_pkg::word_t add_opnd1,
   input  wire vliw_pkg::word_t add_opnd2,
   input  wire vliw_pkg::word_t mul_opnd1,
   input  wire vliw_pkg::word_t mul_opnd2,
   wb_if.lanes                wb
);
   import vliw_pkg::*;

   word_t mul_result;

   assign wb.ld_valid = ld_en;
   assign wb.ld_dest  = ld_dest;
   assign wb.ld_data  = ld_value;

   // Most negative word has no positive twin
   assign wb.neg_valid = neg_en;
   assign wb.neg_dest  = neg_dest;
   assign wb.neg_data  = (neg_opnd == WORD_MIN) ? WORD_MAX : -neg_opnd;

   fx_add_pipe i_add (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (add_en),
      .in_dest   (add_dest),
      .a         (add_opnd1),
      .b         (add_opnd2),
      .out_valid (wb.add_valid),
      .out_dest  (wb.add_dest),
      .sum       (wb.add_data)
   );

   fx_mul i_mul (
      .a       (mul_opnd1),
      .b       (mul_opnd2),
      .product (mul_result)
   );

   assign wb.mul_valid = mul_en;
   assign wb.mul_dest  = mul_dest;
   assign wb.mul_data  = mul_result;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// ============================================================
// Eight-entry register file for the VLIW datapath.
// Five combinational read ports feed the lanes. Write-back is
// applied in lane order ld, neg, add, mul, so the later lane
// wins. Raises done for one cycle once the magnitude register
// reaches one half, then clears z and the magnitude.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  wire                logic clk,
   input  wire                logic rst,
   wb_if.rf                   wb,
   input  wire vliw_pkg::reg_addr_t neg_src,
   input  wire vliw_pkg::reg_addr_t add_src1,
   input  wire vliw_pkg::reg_addr_t add_src2,
   input  wire vliw_pkg::reg_addr_t mul_src1,
   input  wire vliw_pkg::reg_addr_t mul_src2,
   output vliw_pkg::word_t    neg_opnd,
   output vliw_pkg::word_t    add_opnd1,
   output vliw_pkg::word_t    add_opnd2,
   output vliw_pkg::word_t    mul_opnd1,
   output vliw_pkg::word_t    mul_opnd2,
   output logic               done,
   output vliw_pkg::word_t    z_re,
   output vliw_pkg::word_t    z_im
);
   import vliw_pkg::*;

   word_t regs [NUM_REGS];
   logic  mag_escaped;
   logic  dest_clash;

   // ============================================================
   // Read ports
   // ============================================================
   assign neg_opnd  = regs[neg_src];
   assign add_opnd1 = regs[add_src1];
   assign add_opnd2 = regs[add_src2];
   assign mul_opnd1 = regs[mul_src1];
   assign mul_opnd2 = regs[mul_src2];

   assign z_re = regs[ADDR_Z_RE];
   assign z_im = regs[ADDR_Z_IM];

   assign mag_escaped = (regs[ADDR_MAG] >= ESCAPE_LIMIT);

   // ============================================================
   // Write-back and escape clear
   // ============================================================
   always_ff @(posedge clk) begin
      if (wb.ld_valid)  regs[wb.ld_dest]  <= wb.ld_data;
      if (wb.neg_valid) regs[wb.neg_dest] <= wb.neg_data;
      if (wb.add_valid) regs[wb.add_dest] <= wb.add_data;
      if (wb.mul_valid) regs[wb.mul_dest] <= wb.mul_data;
      // Clear overrides any write in the same cycle
      if (rst || done) begin
         regs[ADDR_Z_RE] <= '0;
         regs[ADDR_Z_IM] <= '0;
         regs[ADDR_MAG]  <= '0;
      end
   end

   // One-cycle strobe, held off while already high
   always_ff @(posedge clk) begin
      if (rst) begin
         done <= 1'b0;
      end else begin
         done <= mag_escaped && !done;
      end
   end

   // Any two valid lanes aiming at one register
   assign dest_clash =
      (wb.ld_valid  && wb.neg_valid && wb.ld_dest  == wb.neg_dest) ||
      (wb.ld_valid  && wb.add_valid && wb.ld_dest  == wb.add_dest) ||
      (wb.ld_valid  && wb.mul_valid && wb.ld_dest  == wb.mul_dest) ||
      (wb.neg_valid && wb.add_valid && wb.neg_dest == wb.add_dest) ||
      (wb.neg_valid && wb.mul_valid && wb.neg_dest == wb.mul_dest) ||
      (wb.add_valid && wb.mul_valid && wb.add_dest == wb.mul_dest);

   a_no_dest_clash: assert property (@(posedge clk) disable iff (rst) !dest_clash)
      else $error("Two write-back lanes share a destination");

endmodule

`default_nettype wire

// ==== verilog/vliw_top.sv ====
// ============================================================
// Top level of the fractal VLIW datapath. One four-lane bundle
// is sampled per clock. z_re and z_im expose registers 0 and 1,
// done strobes once the magnitude register escapes.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module vliw_top (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           ld_en,
   input  wire vliw_pkg::reg_addr_t ld_dest,
   input  wire vliw_pkg::word_t ld_value,
   input  wire logic           neg_en,
   input  wire vliw_pkg::reg_addr_t neg_src,
   input  wire vliw_pkg::reg_addr_t neg_dest,
   input  wire logic           add_en,
   input  wire vliw_pkg::reg_addr_t add_src1,
   input  wire vliw_pkg::reg_addr_t add_src2,
   input  wire vliw_pkg::reg_addr_t add_dest,
   input  wire logic           mul_en,
   input  wire vliw_pkg::reg_addr_t mul_src1,
   input  wire vliw_pkg::reg_addr_t mul_src2,
   input  wire vliw_pkg::reg_addr_t mul_dest,
   output logic               done,
   output vliw_pkg::word_t    z_re,
   output vliw_pkg::word_t    z_im
);
   import vliw_pkg::*;

   word_t neg_opnd, add_opnd1, add_opnd2, mul_opnd1, mul_opnd2;

   wb_if wb ();

   reg_file i_rf (
      .clk       (clk),
      .rst       (rst),
      .wb        (wb.rf),
      .neg_src   (neg_src),
      .add_src1  (add_src1),
      .add_src2  (add_src2),
      .mul_src1  (mul_src1),
      .mul_src2  (mul_src2),
      .neg_opnd  (neg_opnd),
      .add_opnd1 (add_opnd1),
      .add_opnd2 (add_opnd2),
      .mul_opnd1 (mul_opnd1),
      .mul_opnd2 (mul_opnd2),
      .done      (done),
      .z_re      (z_re),
      .z_im      (z_im)
   );

   exec_lanes i_lanes (
      .clk       (clk),
      .rst       (rst),
      .ld_en     (ld_en),
      .ld_dest   (ld_dest),
      .ld_value  (ld_value),
      .neg_en    (neg_en),
      .neg_dest  (neg_dest),
      .add_en    (add_en),
      .add_dest  (add_dest),
      .mul_en    (mul_en),
      .mul_dest  (mul_dest),
      .neg_opnd  (neg_opnd),
      .add_opnd1 (add_opnd1),
      .add_opnd2 (add_opnd2),
      .mul_opnd1 (mul_opnd1),
      .mul_opnd2 (mul_opnd2),
      .wb        (wb.lanes)
   );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// ============================================================
// Free-running testbench clock, 40 ns period.
// Starts low at time zero, first rising edge at 20 ns.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk
);
   localparam int HALF_PERIOD = 20;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

endmodule

`default_nettype wire

// ==== dv/vliw_tb.sv ====
// ============================================================
// Testbench for the fractal VLIW datapath.
// Reads one bundle per line from dv/vliw_input.txt, drives it
// shortly after a rising edge and checks z_re, z_im and done
// just before the following edge against the expected columns.
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module vliw_tb;
   import vliw_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 5;
   localparam int DRIVE_DELAY  = 2;
   localparam int CHECK_WAIT   = CLK_PERIOD - DRIVE_DELAY - 2;
   localparam int NUM_LINES    = 19;
   localparam int NUM_FIELDS   = 17;
   localparam int COL_Z_RE     = 14;
   localparam int COL_Z_IM     = 15;
   localparam int COL_DONE     = 16;
   localparam int WATCHDOG_NS  = (NUM_LINES + 20) * CLK_PERIOD;

   logic      clk;
   logic      rst;
   logic      ld_en, neg_en, add_en, mul_en;
   reg_addr_t ld_dest, neg_src, neg_dest;
   reg_addr_t add_src1, add_src2, add_dest;
   reg_addr_t mul_src1, mul_src2, mul_dest;
   word_t     ld_value;
   logic      done;
   word_t     z_re, z_im;

   logic [31:0] vec [NUM_LINES * NUM_FIELDS];

   tb_clock i_clk (
      .clk (clk)
   );

   vliw_top i_dut (
      .clk      (clk),
      .rst      (rst),
      .ld_en    (ld_en),
      .ld_dest  (ld_dest),
      .ld_value (ld_value),
      .neg_en   (neg_en),
      .neg_src  (neg_src),
      .neg_dest (neg_dest),
      .add_en   (add_en),
      .add_src1 (add_src1),
      .add_src2 (add_src2),
      .add_dest (add_dest),
      .mul_en   (mul_en),
      .mul_src1 (mul_src1),
      .mul_src2 (mul_src2),
      .mul_dest (mul_dest),
      .done     (done),
      .z_re     (z_re),
      .z_im     (z_im)
   );

   // ============================================================
   // Stimulus and checking helpers
   // ============================================================
   task automatic report_mismatch(input string what, input string where,
                                  input logic [26:0] expected,
                                  input logic [26:0] actual);
      $display("error: time %0t, %s: %s expected %h, got %h",
               $time, where, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "Stopped at first mismatch");
   endtask

   task automatic check_outputs(input string where, input logic [26:0] exp_re,
                                input logic [26:0] exp_im, input logic exp_done);
      assert (z_re === exp_re) else report_mismatch("z_re", where, exp_re, z_re);
      assert (z_im === exp_im) else report_mismatch("z_im", where, exp_im, z_im);
      assert (done === exp_done) else report_mismatch("done", where, exp_done, done);
   endtask

   task automatic drive_idle();
      ld_en    = 1'b0;
      ld_dest  = '0;
      ld_value = '0;
      neg_en   = 1'b0;
      neg_src  = '0;
      neg_dest = '0;
      add_en   = 1'b0;
      add_src1 = '0;
      add_src2 = '0;
      add_dest = '0;
      mul_en   = 1'b0;
      mul_src1 = '0;
      mul_src2 = '0;
      mul_dest = '0;
   endtask

   // Column order follows the header of the input file
   task automatic drive_bundle(input int idx);
      int base;
      base     = idx * NUM_FIELDS;
      ld_en    = vec[base + 0][0];
      ld_dest  = vec[base + 1][2:0];
      ld_value = vec[base + 2][26:0];
      neg_en   = vec[base + 3][0];
      neg_src  = vec[base + 4][2:0];
      neg_dest = vec[base + 5][2:0];
      add_en   = vec[base + 6][0];
      add_src1 = vec[base + 7][2:0];
      add_src2 = vec[base + 8][2:0];
      add_dest = vec[base + 9][2:0];
      mul_en   = vec[base + 10][0];
      mul_src1 = vec[base + 11][2:0];
      mul_src2 = vec[base + 12][2:0];
      mul_dest = vec[base + 13][2:0];
   endtask

   task automatic check_line(input int idx);
      int base;
      base = idx * NUM_FIELDS;
      check_outputs($sformatf("vector line %0d", idx), vec[base + COL_Z_RE][26:0],
                    vec[base + COL_Z_IM][26:0], vec[base + COL_DONE][0]);
   endtask

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      rst = 1'b1;
      drive_idle();
      $readmemh("dv/vliw_input.txt", vec);

      // Edges 1 to 4 of reset
      repeat (RESET_CYCLES - 1) begin
         @(posedge clk);
         #(DRIVE_DELAY + CHECK_WAIT);
         check_outputs("reset", '0, '0, 1'b0);
      end

      // Edge 5 is the last one that samples reset
      @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      drive_bundle(0);
      #CHECK_WAIT;
      check_outputs("end of reset", '0, '0, 1'b0);

      for (int i = 1; i <= NUM_LINES; i++) begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (i < NUM_LINES) begin
            drive_bundle(i);
         end else begin
            drive_idle();
         end
         #CHECK_WAIT;
         check_line(i - 1);
      end

      $display("Test OK");
      $finish;
   end

   initial begin
      #WATCHDOG_NS;
      $display("Timeout: the run did not finish within the expected time");
      $display("Test FAILED");
      $fatal(1, "Watchdog expired");
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/vliw_pkg.sv
verilog/wb_if.sv
verilog/fx_add_pipe.sv
verilog/fx_mul.sv
verilog/exec_lanes.sv
verilog/reg_file.sv
verilog/vliw_top.sv
dv/tb_clock.sv
dv/vliw_tb.sv

// ==== Bender.yml ====
package:
  name: vliw_fractal

sources:
  - verilog/vliw_pkg.sv
  - verilog/wb_if.sv
  - verilog/fx_add_pipe.sv
  - verilog/fx_mul.sv
  - verilog/exec_lanes.sv
  - verilog/reg_file.sv
  - verilog/vliw_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/vliw_tb.sv

// ==== dv/vliw_input.txt ====
// ld_en ld_dest ld_value | neg_en src dest | add_en src1 src2 dest | mul_en src1 src2 dest | z_re z_im done
// Words are 27-bit two's complement with 22 fraction bits; last three columns are expected after the sampling edge
1 3 0300000  0 0 0  0 0 0 0  0 0 0 0  0000000 0000000 0
1 4 4000000  1 3 0  0 0 0 0  0 0 0 0  7D00000 0000000 0
1 0 0123456  1 4 1  0 0 0 0  0 0 0 0  0123456 3FFFFFF 0
1 5 0600001  0 0 0  0 0 0 0  0 0 0 0  0123456 3FFFFFF 0
1 6 7A00000  0 0 0  0 0 0 0  0 0 0 0  0123456 3FFFFFF 0
1 7 3000000  0 0 0  0 0 0 0  0 0 0 0  0123456 3FFFFFF 0
0 0 0000000  0 0 0  0 0 0 0  1 5 6 0  76FFFFE 3FFFFFF 0
0 0 0000000  0 0 0  0 0 0 0  1 7 6 1  76FFFFE 4000000 0
0 0 0000000  0 0 0  1 3 5 0  0 0 0 0  76FFFFE 4000000 0
0 0 0000000  0 0 0  1 7 7 1  0 0 0 0  76FFFFE 4000000 0
0 0 0000000  0 0 0  0 0 0 0  0 0 0 0  76FFFFE 4000000 0
0 0 0000000  0 0 0  0 0 0 0  0 0 0 0  0900001 4000000 0
0 0 0000000  0 0 0  0 0 0 0  0 0 0 0  0900001 3FFFFFF 0
1 4 0100000  1 5 0  0 0 0 0  1 3 3 1  79FFFFF 0240000 0
1 2 01FFFFF  0 0 0  0 0 0 0  0 0 0 0  79FFFFF 0240000 0
1 2 0200000  0 0 0  0 0 0 0  0 0 0 0  79FFFFF 0240000 0
0 0 0000000  0 0 0  0 0 0 0  0 0 0 0  79FFFFF 0240000 1
0 0 0000000  0 0 0  0 0 0 0  0 0 0 0  0000000 0000000 0
0 0 0000000  0 0 0  0 0 0 0  0 0 0 0  0000000 0000000 0
